// ==== tcls.f ====
+incdir+src
src/tcls_bus_pkg.sv
src/tcls_reg_pkg.sv
src/tcls_voter.sv
src/tcls_regs.sv
src/tcls_recovery_fsm.sv
src/tcls_unit.sv
verification/tcls_clk_gen.sv
verification/tcls_tb.sv

// ==== Makefile ====
TOP := tcls_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f tcls.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee run.log
	grep -q "No errors" run.log

clean:
	rm -rf obj_dir run.log

// ==== verification/tcls_tb.sv ====
// Random lock-step stimulus from a fixed LCG seed; stops at the first mismatch with the model
`timescale 1ns/1ps

module tcls_tb;

  import tcls_bus_pkg::*;
  import tcls_reg_pkg::*;

  localparam int unsigned N_AGREE  = 100;
  localparam int unsigned N_SINGLE = 300;
  localparam int unsigned N_SAT    = 300;
  localparam int unsigned N_MULTI  = 200;
  // Recovery loop runs 4 rounds of 10 cycles, the rest is setup, clears and fetch enable
  localparam int unsigned TEST_CYCLES = N_AGREE + N_SINGLE + N_SAT + N_MULTI + 4 * 10 + 30;
  localparam int unsigned CYCLE_LIMIT = TEST_CYCLES + 100;

  logic clk;
  logic rst_n;
  logic reg_req;
  logic reg_we;
  reg_addr_t reg_addr;
  data_t reg_wdata;
  data_t reg_rdata;
  data_t intc_irq;
  data_t intc_instr_rdata;
  data_t intc_data_rdata;
  data_t hart_id;
  addr_t boot_addr;
  logic intc_instr_gnt;
  logic intc_instr_rvalid;
  logic intc_instr_err;
  logic intc_data_gnt;
  logic intc_data_rvalid;
  logic intc_data_err;
  logic fetch_en;
  logic debug_req;
  // Voted requests towards the interconnect
  logic irq_ack;
  irq_id_t irq_ack_id;
  logic instr_req;
  addr_t instr_addr;
  logic data_req;
  addr_t data_addr;
  logic data_we;
  data_t data_wdata;
  be_t data_be;
  // Per-core requests, index is the core
  logic [2:0] c_ack;
  irq_id_t [2:0] c_ack_id;
  logic [2:0] c_ireq;
  addr_t [2:0] c_iaddr;
  logic [2:0] c_dreq;
  addr_t [2:0] c_daddr;
  logic [2:0] c_dwe;
  data_t [2:0] c_dwdata;
  be_t [2:0] c_dbe;
  // Fan-out to the cores
  data_t [2:0] f_irq;
  data_t [2:0] f_irdata;
  data_t [2:0] f_drdata;
  data_t [2:0] f_hart;
  addr_t [2:0] f_boot;
  logic [2:0] f_igt;
  logic [2:0] f_irvalid;
  logic [2:0] f_ierr;
  logic [2:0] f_dgnt;
  logic [2:0] f_drvalid;
  logic [2:0] f_derr;
  logic [2:0] f_fetch;
  logic [2:0] f_dbg;
  logic [2:0] setback;
  logic mismatch;
  logic multi_mismatch;

  // Reference model state
  tcls_mode_e m_mode;
  logic m_setback;
  logic m_sb_en;
  logic m_rl_en;
  logic m_restore;
  data_t m_sp;
  cnt_t m_cnt [3];
  reg_addr_t cnt_off [3] = '{REG_MISMATCH0, REG_MISMATCH1, REG_MISMATCH2};

  logic [31:0] seed = 32'h37f6_9f57;
  int unsigned cycle_cnt = 0;

  tcls_clk_gen u_clk_gen (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  tcls_unit u_tcls_unit (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .reg_req_i           (reg_req),
    .reg_we_i            (reg_we),
    .reg_addr_i          (reg_addr),
    .reg_wdata_i         (reg_wdata),
    .reg_rdata_o         (reg_rdata),
    .intc_irq_i          (intc_irq),
    .intc_irq_ack_o      (irq_ack),
    .intc_irq_ack_id_o   (irq_ack_id),
    .intc_instr_req_o    (instr_req),
    .intc_instr_addr_o   (instr_addr),
    .intc_instr_gnt_i    (intc_instr_gnt),
    .intc_instr_rdata_i  (intc_instr_rdata),
    .intc_instr_rvalid_i (intc_instr_rvalid),
    .intc_instr_err_i    (intc_instr_err),
    .intc_data_req_o     (data_req),
    .intc_data_addr_o    (data_addr),
    .intc_data_we_o      (data_we),
    .intc_data_wdata_o   (data_wdata),
    .intc_data_be_o      (data_be),
    .intc_data_gnt_i     (intc_data_gnt),
    .intc_data_rdata_i   (intc_data_rdata),
    .intc_data_rvalid_i  (intc_data_rvalid),
    .intc_data_err_i     (intc_data_err),
    .intc_fetch_en_i     (fetch_en),
    .intc_boot_addr_i    (boot_addr),
    .intc_hart_id_i      (hart_id),
    .intc_debug_req_i    (debug_req),
    .core_irq_o          (f_irq),
    .core_irq_ack_i      (c_ack),
    .core_irq_ack_id_i   (c_ack_id),
    .core_instr_req_i    (c_ireq),
    .core_instr_addr_i   (c_iaddr),
    .core_instr_gnt_o    (f_igt),
    .core_instr_rdata_o  (f_irdata),
    .core_instr_rvalid_o (f_irvalid),
    .core_instr_err_o    (f_ierr),
    .core_data_req_i     (c_dreq),
    .core_data_addr_i    (c_daddr),
    .core_data_we_i      (c_dwe),
    .core_data_wdata_i   (c_dwdata),
    .core_data_be_i      (c_dbe),
    .core_data_gnt_o     (f_dgnt),
    .core_data_rdata_o   (f_drdata),
    .core_data_rvalid_o  (f_drvalid),
    .core_data_err_o     (f_derr),
    .core_fetch_en_o     (f_fetch),
    .core_boot_addr_o    (f_boot),
    .core_hart_id_o      (f_hart),
    .core_debug_req_o    (f_dbg),
    .core_setback_o      (setback),
    .mismatch_o          (mismatch),
    .multi_mismatch_o    (multi_mismatch)
  );

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // Each result bit follows at least two of the three inputs
  function automatic logic [63:0] vote(input logic [63:0] a, input logic [63:0] b,
                                       input logic [63:0] c);
    logic [63:0] m;
    for (int i = 0; i < 64; i++) begin
      m[i] = (int'(a[i]) + int'(b[i]) + int'(c[i])) >= 2;
    end
    return m;
  endfunction

  function automatic core_mask_t outvoted(input logic [63:0] a, input logic [63:0] b,
                                          input logic [63:0] c);
    logic [63:0] m;
    m = vote(a, b, c);
    return {c != m, b != m, a != m};
  endfunction

  function automatic core_mask_t expected_blame();
    core_mask_t mb;
    core_mask_t db;
    mb = outvoted(c_ack[0], c_ack[1], c_ack[2]) |
         outvoted(c_ack_id[0], c_ack_id[1], c_ack_id[2]) |
         outvoted(c_ireq[0], c_ireq[1], c_ireq[2]) |
         outvoted(c_iaddr[0], c_iaddr[1], c_iaddr[2]) |
         outvoted(c_dreq[0], c_dreq[1], c_dreq[2]);
    db = outvoted(c_daddr[0], c_daddr[1], c_daddr[2]) |
         outvoted(c_dwe[0], c_dwe[1], c_dwe[2]) |
         outvoted(c_dwdata[0], c_dwdata[1], c_dwdata[2]) |
         outvoted(c_dbe[0], c_dbe[1], c_dbe[2]);
    if (vote(c_dreq[0], c_dreq[1], c_dreq[2]) != 0) begin
      mb = mb | db;
    end
    return mb;
  endfunction

  task automatic check(input string name, input logic [255:0] got, input logic [255:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s: got %0h expected %0h", $time, name, got, exp);
      $display("Errors found");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  task automatic drive_agreement();
    logic [31:0] r;
    addr_t ia;
    addr_t da;
    data_t wd;
    r = lcg_next();
    ia = lcg_next();
    da = lcg_next();
    wd = lcg_next();
    for (int i = 0; i < 3; i++) begin
      c_ack[i]    = r[0];
      c_ack_id[i] = r[5:1];
      c_ireq[i]   = r[6];
      c_iaddr[i]  = ia;
      c_dreq[i]   = r[7];
      c_daddr[i]  = da;
      c_dwe[i]    = r[8];
      c_dwdata[i] = wd;
      c_dbe[i]    = r[12:9];
    end
    intc_irq          = lcg_next();
    intc_instr_rdata  = lcg_next();
    intc_data_rdata   = lcg_next();
    boot_addr         = lcg_next();
    hart_id           = lcg_next();
    intc_instr_gnt    = r[13];
    intc_instr_rvalid = r[14];
    intc_instr_err    = r[15];
    intc_data_gnt     = r[16];
    intc_data_rvalid  = r[17];
    intc_data_err     = r[18];
    debug_req         = r[19];
  endtask

  // Fields 0 to 4 go to the main voter, 5 to 8 to the data voter
  task automatic flip_bit(input int core, input int sel);
    logic [31:0] r;
    r = lcg_next();
    case (sel)
      0: c_ack[core] = ~c_ack[core];
      1: c_ack_id[core] = c_ack_id[core] ^ irq_id_t'(1 << (r % 5));
      2: c_ireq[core] = ~c_ireq[core];
      3: c_iaddr[core] = c_iaddr[core] ^ (32'd1 << r[4:0]);
      4: c_dreq[core] = ~c_dreq[core];
      5: c_daddr[core] = c_daddr[core] ^ (32'd1 << r[4:0]);
      6: c_dwe[core] = ~c_dwe[core];
      7: c_dwdata[core] = c_dwdata[core] ^ (32'd1 << r[4:0]);
      default: c_dbe[core] = c_dbe[core] ^ (4'd1 << r[1:0]);
    endcase
  endtask

  task automatic start_write(input reg_addr_t addr, input data_t data);
    reg_req   = 1'b1;
    reg_we    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
  endtask

  task automatic read_check(input reg_addr_t addr, input data_t exp);
    reg_addr = addr;
    #1;
    check($sformatf("reg_rdata_o at %0h", addr), reg_rdata, exp);
  endtask

  task automatic read_all_regs();
    read_check(REG_CONFIG, data_t'({m_rl_en, m_sb_en}));
    read_check(REG_MODE, data_t'({m_mode, m_restore}));
    read_check(REG_SP_STORE, m_sp);
    for (int i = 0; i < 3; i++) begin
      read_check(cnt_off[i], data_t'(m_cnt[i]));
    end
    // Unmapped offset
    read_check(5'h1C, '0);
  endtask

  task automatic expect_mode(input tcls_mode_e mode);
    reg_addr = REG_MODE;
    #1;
    check("REG_MODE state", reg_rdata[2:1], mode);
  endtask

  task automatic check_outputs();
    core_mask_t b;
    b = expected_blame();
    check("intc_irq_ack_o", irq_ack, vote(c_ack[0], c_ack[1], c_ack[2]));
    check("intc_irq_ack_id_o", irq_ack_id, vote(c_ack_id[0], c_ack_id[1], c_ack_id[2]));
    check("intc_instr_req_o", instr_req, vote(c_ireq[0], c_ireq[1], c_ireq[2]));
    check("intc_instr_addr_o", instr_addr, vote(c_iaddr[0], c_iaddr[1], c_iaddr[2]));
    check("intc_data_req_o", data_req, vote(c_dreq[0], c_dreq[1], c_dreq[2]));
    check("intc_data_addr_o", data_addr, vote(c_daddr[0], c_daddr[1], c_daddr[2]));
    check("intc_data_we_o", data_we, vote(c_dwe[0], c_dwe[1], c_dwe[2]));
    check("intc_data_wdata_o", data_wdata, vote(c_dwdata[0], c_dwdata[1], c_dwdata[2]));
    check("intc_data_be_o", data_be, vote(c_dbe[0], c_dbe[1], c_dbe[2]));
    check("mismatch_o", mismatch, b != 3'b000);
    check("multi_mismatch_o", multi_mismatch, $countones(b) >= 2);
    for (int i = 0; i < 3; i++) begin
      check($sformatf("core fan-out %0d", i),
            {f_irq[i], f_igt[i], f_irdata[i], f_irvalid[i], f_ierr[i], f_dgnt[i],
             f_drdata[i], f_drvalid[i], f_derr[i], f_fetch[i], f_boot[i], f_hart[i], f_dbg[i]},
            {intc_irq, intc_instr_gnt, intc_instr_rdata, intc_instr_rvalid, intc_instr_err,
             intc_data_gnt, intc_data_rdata, intc_data_rvalid, intc_data_err, fetch_en,
             boot_addr, hart_id, debug_req});
    end
  endtask

  // Recovery rules applied at a rising edge to the inputs of the ending cycle
  task automatic model_edge();
    core_mask_t b;
    logic wr;
    logic zero_wr;
    tcls_mode_e nxt;
    logic sb;
    b = expected_blame();
    wr = reg_req & reg_we;
    zero_wr = wr && reg_addr == REG_SP_STORE && reg_wdata == '0;
    nxt = m_mode;
    sb = 1'b0;
    case (m_mode)
      TCLS_RUN: begin
        if (b != 3'b000 && !m_restore) begin
          nxt = TCLS_UNLOAD;
        end
      end
      TCLS_UNLOAD: begin
        if (m_sp != '0) begin
          nxt = TCLS_RELOAD;
          sb = m_sb_en;
        end
      end
      default: begin
        if (m_sp == '0) begin
          nxt = TCLS_RUN;
        end else if (b != 3'b000 && m_sb_en && m_rl_en && !zero_wr) begin
          sb = 1'b1;
        end
      end
    endcase
    if (!fetch_en) begin
      nxt = TCLS_RUN;
      sb = 1'b0;
    end
    for (int i = 0; i < 3; i++) begin
      if (wr && reg_addr == cnt_off[i]) begin
        m_cnt[i] = '0;
      end else if (m_mode == TCLS_RUN && b[i] && m_cnt[i] != '1) begin
        m_cnt[i] = m_cnt[i] + 1;
      end
    end
    if (wr && reg_addr == REG_CONFIG) begin
      m_sb_en = reg_wdata[0];
      m_rl_en = reg_wdata[1];
    end
    if (wr && reg_addr == REG_MODE) begin
      m_restore = reg_wdata[0];
    end
    if (wr && reg_addr == REG_SP_STORE) begin
      m_sp = reg_wdata;
    end
    m_mode = nxt;
    m_setback = sb;
  endtask

  // Called on a falling edge with the inputs already driven, returns on the next one
  task automatic run_cycle();
    #1;
    check_outputs();
    @(posedge clk);
    model_edge();
    @(negedge clk);
    reg_req = 1'b0;
    reg_we  = 1'b0;
    check("core_setback_o", setback, {3{m_setback}});
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Errors found");
      $fatal(1, "timeout");
    end
  end

  initial begin
    int k;
    int s;
    reg_req = 1'b0;
    reg_we = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    fetch_en = 1'b1;
    drive_agreement();
    m_mode = TCLS_RUN;
    m_setback = 1'b0;
    m_sb_en = 1'b0;
    m_rl_en = 1'b0;
    m_restore = 1'b0;
    m_sp = '0;
    for (int i = 0; i < 3; i++) begin
      m_cnt[i] = '0;
    end
    @(posedge rst_n);
    read_all_regs();
    // Restore mode keeps the FSM in run so that every blame is counted
    start_write(REG_CONFIG, 32'h3);
    run_cycle();
    start_write(REG_MODE, 32'h1);
    run_cycle();
    repeat (N_AGREE) begin
      drive_agreement();
      read_all_regs();
      run_cycle();
    end
    repeat (N_SINGLE) begin
      drive_agreement();
      flip_bit(lcg_next() % 3, lcg_next() % 9);
      read_all_regs();
      run_cycle();
    end
    // Core 1 loses every vote until its counter saturates
    repeat (N_SAT) begin
      drive_agreement();
      flip_bit(1, lcg_next() % 5);
      run_cycle();
    end
    read_check(REG_MISMATCH1, 32'hFF);
    repeat (N_MULTI) begin
      drive_agreement();
      k = lcg_next() % 3;
      s = lcg_next() % 9;
      flip_bit(k, s);
      flip_bit((k + 1) % 3, (s + 1 + lcg_next() % 8) % 9);
      read_all_regs();
      run_cycle();
    end
    for (int i = 0; i < 3; i++) begin
      drive_agreement();
      start_write(cnt_off[i], lcg_next());
      run_cycle();
      read_all_regs();
      read_check(cnt_off[i], '0);
    end
    for (int r = 0; r < 4; r++) begin
      drive_agreement();
      start_write(REG_CONFIG, r);
      run_cycle();
      start_write(REG_MODE, 32'h0);
      run_cycle();
      flip_bit(lcg_next() % 3, lcg_next() % 5);
      run_cycle();
      drive_agreement();
      expect_mode(TCLS_UNLOAD);
      start_write(REG_SP_STORE, lcg_next() | 32'h1);
      run_cycle();
      run_cycle();
      check("core_setback_o after unload", setback, {3{r[0]}});
      expect_mode(TCLS_RELOAD);
      run_cycle();
      flip_bit(lcg_next() % 3, lcg_next() % 5);
      run_cycle();
      drive_agreement();
      flip_bit(lcg_next() % 3, lcg_next() % 5);
      start_write(REG_SP_STORE, '0);
      run_cycle();
      drive_agreement();
      run_cycle();
      expect_mode(TCLS_RUN);
      read_all_regs();
      run_cycle();
    end
    // Fetch enable drop from unload, then from reload
    flip_bit(0, 0);
    run_cycle();
    drive_agreement();
    expect_mode(TCLS_UNLOAD);
    fetch_en = 1'b0;
    run_cycle();
    expect_mode(TCLS_RUN);
    fetch_en = 1'b1;
    flip_bit(2, 1);
    run_cycle();
    drive_agreement();
    start_write(REG_SP_STORE, 32'h40);
    run_cycle();
    run_cycle();
    expect_mode(TCLS_RELOAD);
    // This blame would pulse setback in reload if fetch stayed enabled
    flip_bit(1, 3);
    fetch_en = 1'b0;
    run_cycle();
    expect_mode(TCLS_RUN);
    fetch_en = 1'b1;
    drive_agreement();
    start_write(REG_SP_STORE, '0);
    run_cycle();
    read_all_regs();
    run_cycle();
    $display("No errors");
    $finish;
  end

endmodule

// ==== verification/tcls_clk_gen.sv ====
// 20 ns clock starting low; reset is held for 3 rising edges and released on a falling edge
`timescale 1ns/1ps

module tcls_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (3) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// ==== src/tcls_unit.sv ====
// Three-core lock-step top; voting and fan-out are combinational, no FPU port, no back-pressure
`timescale 1ns/1ps
`include "tcls_config.svh"

module tcls_unit (
  input  logic                                 clk_i,
  input  logic                                 rst_ni,
  // Register port
  input  logic                                 reg_req_i,
  input  logic                                 reg_we_i,
  input  tcls_reg_pkg::reg_addr_t              reg_addr_i,
  input  tcls_bus_pkg::data_t                  reg_wdata_i,
  output tcls_bus_pkg::data_t                  reg_rdata_o,
  // Interconnect side
  input  tcls_bus_pkg::data_t                  intc_irq_i,
  output logic                                 intc_irq_ack_o,
  output tcls_bus_pkg::irq_id_t                intc_irq_ack_id_o,
  output logic                                 intc_instr_req_o,
  output tcls_bus_pkg::addr_t                  intc_instr_addr_o,
  input  logic                                 intc_instr_gnt_i,
  input  tcls_bus_pkg::data_t                  intc_instr_rdata_i,
  input  logic                                 intc_instr_rvalid_i,
  input  logic                                 intc_instr_err_i,
  output logic                                 intc_data_req_o,
  output tcls_bus_pkg::addr_t                  intc_data_addr_o,
  output logic                                 intc_data_we_o,
  output tcls_bus_pkg::data_t                  intc_data_wdata_o,
  output tcls_bus_pkg::be_t                    intc_data_be_o,
  input  logic                                 intc_data_gnt_i,
  input  tcls_bus_pkg::data_t                  intc_data_rdata_i,
  input  logic                                 intc_data_rvalid_i,
  input  logic                                 intc_data_err_i,
  input  logic                                 intc_fetch_en_i,
  input  tcls_bus_pkg::addr_t                  intc_boot_addr_i,
  input  tcls_bus_pkg::data_t                  intc_hart_id_i,
  input  logic                                 intc_debug_req_i,
  // Core side, index is the core
  output tcls_bus_pkg::data_t   [2:0]          core_irq_o,
  input  logic                  [2:0]          core_irq_ack_i,
  input  tcls_bus_pkg::irq_id_t [2:0]          core_irq_ack_id_i,
  input  logic                  [2:0]          core_instr_req_i,
  input  tcls_bus_pkg::addr_t   [2:0]          core_instr_addr_i,
  output logic                  [2:0]          core_instr_gnt_o,
  output tcls_bus_pkg::data_t   [2:0]          core_instr_rdata_o,
  output logic                  [2:0]          core_instr_rvalid_o,
  output logic                  [2:0]          core_instr_err_o,
  input  logic                  [2:0]          core_data_req_i,
  input  tcls_bus_pkg::addr_t   [2:0]          core_data_addr_i,
  input  logic                  [2:0]          core_data_we_i,
  input  tcls_bus_pkg::data_t   [2:0]          core_data_wdata_i,
  input  tcls_bus_pkg::be_t     [2:0]          core_data_be_i,
  output logic                  [2:0]          core_data_gnt_o,
  output tcls_bus_pkg::data_t   [2:0]          core_data_rdata_o,
  output logic                  [2:0]          core_data_rvalid_o,
  output logic                  [2:0]          core_data_err_o,
  output logic                  [2:0]          core_fetch_en_o,
  output tcls_bus_pkg::addr_t   [2:0]          core_boot_addr_o,
  output tcls_bus_pkg::data_t   [2:0]          core_hart_id_o,
  output logic                  [2:0]          core_debug_req_o,
  output logic                  [2:0]          core_setback_o,
  output logic                                 mismatch_o,
  output logic                                 multi_mismatch_o
);

  import tcls_bus_pkg::*;
  import tcls_reg_pkg::*;

  // irq_ack, irq_ack_id, instr_req, instr_addr, data_req
  localparam int unsigned main_w = 1 + `TCLS_IRQ_ID_W + 1 + `TCLS_ADDR_W + 1;
  // data_addr, data_we, data_wdata, data_be
  localparam int unsigned data_w = `TCLS_ADDR_W + 1 + `TCLS_DATA_W + `TCLS_BE_W;

  logic [2:0][main_w-1:0] main_in;
  logic [2:0][data_w-1:0] data_in;
  logic      [main_w-1:0] main_vote;
  logic      [data_w-1:0] data_vote;
  core_mask_t             main_err_cba;
  core_mask_t             data_err_cba;
  core_mask_t             count_inc;
  tcls_mode_e             mode;
  logic                   setback_en;
  logic                   reload_setback_en;
  logic                   restore_mode;
  data_t                  sp_store;
  logic                   sp_zero_write;
  logic                   setback;

  for (genvar i = 0; i < 3; i++) begin : gen_pack
    assign main_in[i] = {core_irq_ack_i[i], core_irq_ack_id_i[i],
                         core_instr_req_i[i], core_instr_addr_i[i], core_data_req_i[i]};
    assign data_in[i] = {core_data_addr_i[i], core_data_we_i[i],
                         core_data_wdata_i[i], core_data_be_i[i]};
  end

  tcls_voter #(
    .Width ( main_w )
  ) u_main_voter (
    .a_i           ( main_in[0]   ),
    .b_i           ( main_in[1]   ),
    .c_i           ( main_in[2]   ),
    .majority_o    ( main_vote    ),
    .error_cba_o   ( main_err_cba ),
    .multi_error_o (              )
  );

  // Data fields only need to agree during a data request
  tcls_voter #(
    .Width ( data_w )
  ) u_data_voter (
    .a_i           ( data_in[0]   ),
    .b_i           ( data_in[1]   ),
    .c_i           ( data_in[2]   ),
    .majority_o    ( data_vote    ),
    .error_cba_o   ( data_err_cba ),
    .multi_error_o (              )
  );

  assign {intc_irq_ack_o, intc_irq_ack_id_o,
          intc_instr_req_o, intc_instr_addr_o, intc_data_req_o} = main_vote;
  assign {intc_data_addr_o, intc_data_we_o, intc_data_wdata_o, intc_data_be_o} = data_vote;

  tcls_regs u_regs (
    .clk_i               ( clk_i             ),
    .rst_ni              ( rst_ni            ),
    .reg_req_i           ( reg_req_i         ),
    .reg_we_i            ( reg_we_i          ),
    .reg_addr_i          ( reg_addr_i        ),
    .reg_wdata_i         ( reg_wdata_i       ),
    .reg_rdata_o         ( reg_rdata_o       ),
    .mode_i              ( mode              ),
    .count_inc_i         ( count_inc         ),
    .setback_en_o        ( setback_en        ),
    .reload_setback_en_o ( reload_setback_en ),
    .restore_mode_o      ( restore_mode      ),
    .sp_store_o          ( sp_store          ),
    .sp_zero_write_o     ( sp_zero_write     )
  );

  tcls_recovery_fsm u_recovery_fsm (
    .clk_i               ( clk_i             ),
    .rst_ni              ( rst_ni            ),
    .fetch_en_i          ( intc_fetch_en_i   ),
    .main_err_cba_i      ( main_err_cba      ),
    .data_err_cba_i      ( data_err_cba      ),
    .data_req_i          ( intc_data_req_o   ),
    .setback_en_i        ( setback_en        ),
    .reload_setback_en_i ( reload_setback_en ),
    .restore_mode_i      ( restore_mode      ),
    .sp_store_i          ( sp_store          ),
    .sp_zero_write_i     ( sp_zero_write     ),
    .mode_o              ( mode              ),
    .count_inc_o         ( count_inc         ),
    .mismatch_o          ( mismatch_o        ),
    .multi_mismatch_o    ( multi_mismatch_o  ),
    .setback_o           ( setback           )
  );

  // Responses and control go to all three cores unchanged
  assign core_irq_o          = {3{intc_irq_i}};
  assign core_instr_gnt_o    = {3{intc_instr_gnt_i}};
  assign core_instr_rdata_o  = {3{intc_instr_rdata_i}};
  assign core_instr_rvalid_o = {3{intc_instr_rvalid_i}};
  assign core_instr_err_o    = {3{intc_instr_err_i}};
  assign core_data_gnt_o     = {3{intc_data_gnt_i}};
  assign core_data_rdata_o   = {3{intc_data_rdata_i}};
  assign core_data_rvalid_o  = {3{intc_data_rvalid_i}};
  assign core_data_err_o     = {3{intc_data_err_i}};
  assign core_fetch_en_o     = {3{intc_fetch_en_i}};
  assign core_boot_addr_o    = {3{intc_boot_addr_i}};
  assign core_hart_id_o      = {3{intc_hart_id_i}};
  assign core_debug_req_o    = {3{intc_debug_req_i}};
  assign core_setback_o      = {3{setback}};

endmodule

// ==== src/tcls_recovery_fsm.sv ====
// Recovery FSM; blame counting and flags are combinational, setback is a one-cycle registered pulse
`timescale 1ns/1ps

module tcls_recovery_fsm (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     fetch_en_i,
  input  tcls_bus_pkg::core_mask_t main_err_cba_i,
  input  tcls_bus_pkg::core_mask_t data_err_cba_i,
  input  logic                     data_req_i,
  input  logic                     setback_en_i,
  input  logic                     reload_setback_en_i,
  input  logic                     restore_mode_i,
  input  tcls_bus_pkg::data_t      sp_store_i,
  input  logic                     sp_zero_write_i,
  output tcls_reg_pkg::tcls_mode_e mode_o,
  output tcls_bus_pkg::core_mask_t count_inc_o,
  output logic                     mismatch_o,
  output logic                     multi_mismatch_o,
  output logic                     setback_o
);

  import tcls_bus_pkg::*;
  import tcls_reg_pkg::*;

  core_mask_t blame;
  tcls_mode_e mode_d, mode_q;
  logic       setback_d, setback_q;

  // Data bus fields only matter while a data request is voted
  assign blame = main_err_cba_i | (data_req_i ? data_err_cba_i : 3'b000);

  assign mismatch_o       = (blame != 3'b000);
  assign multi_mismatch_o = (blame[0] & blame[1]) | (blame[0] & blame[2]) | (blame[1] & blame[2]);

  // Blames are counted only while running
  assign count_inc_o = (mode_q == TCLS_RUN) ? blame : 3'b000;

  always_comb begin
    mode_d    = mode_q;
    setback_d = 1'b0;
    case (mode_q)
      TCLS_RUN: begin
        if (mismatch_o && !restore_mode_i) begin
          mode_d = TCLS_UNLOAD;
        end
      end
      TCLS_UNLOAD: begin
        // Software has saved state once sp_store turns nonzero
        if (sp_store_i != '0) begin
          mode_d    = TCLS_RELOAD;
          setback_d = setback_en_i;
        end
      end
      TCLS_RELOAD: begin
        if (sp_store_i == '0) begin
          mode_d = TCLS_RUN;
        end else if (mismatch_o && setback_en_i && reload_setback_en_i && !sp_zero_write_i) begin
          setback_d = 1'b1;
        end
      end
      default: mode_d = TCLS_RUN;
    endcase
    // Cores halted, so there is nothing to recover
    if (!fetch_en_i) begin
      mode_d    = TCLS_RUN;
      setback_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q    <= TCLS_RUN;
      setback_q <= 1'b0;
    end else begin
      mode_q    <= mode_d;
      setback_q <= setback_d;
    end
  end

  assign mode_o    = mode_q;
  assign setback_o = setback_q;

  // A setback only follows a step into or within reload
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    setback_q |-> (mode_q == TCLS_RELOAD))
    else $error("setback pulsed outside reload");

endmodule

// ==== src/tcls_regs.sv ====
// Register block without handshake; writes need req and we high, reads are combinational
`timescale 1ns/1ps

module tcls_regs (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      reg_req_i,
  input  logic                      reg_we_i,
  input  tcls_reg_pkg::reg_addr_t   reg_addr_i,
  input  tcls_bus_pkg::data_t       reg_wdata_i,
  output tcls_bus_pkg::data_t       reg_rdata_o,
  input  tcls_reg_pkg::tcls_mode_e  mode_i,
  input  tcls_bus_pkg::core_mask_t  count_inc_i,
  output logic                      setback_en_o,
  output logic                      reload_setback_en_o,
  output logic                      restore_mode_o,
  output tcls_bus_pkg::data_t       sp_store_o,
  output logic                      sp_zero_write_o
);

  import tcls_bus_pkg::*;
  import tcls_reg_pkg::*;

  localparam cnt_t cnt_max = '1;

  logic       wr_en;
  logic       setback_en_q;
  logic       reload_setback_en_q;
  logic       restore_mode_q;
  data_t      sp_store_q;
  cnt_t       cnt_q [3];
  core_mask_t cnt_clr;

  assign wr_en = reg_req_i & reg_we_i;

  // Counter clears, one per core
  assign cnt_clr[0] = wr_en && (reg_addr_i == REG_MISMATCH0);
  assign cnt_clr[1] = wr_en && (reg_addr_i == REG_MISMATCH1);
  assign cnt_clr[2] = wr_en && (reg_addr_i == REG_MISMATCH2);

  assign sp_zero_write_o = wr_en && (reg_addr_i == REG_SP_STORE) && (reg_wdata_i == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      setback_en_q        <= 1'b0;
      reload_setback_en_q <= 1'b0;
      restore_mode_q      <= 1'b0;
      sp_store_q          <= '0;
      for (int i = 0; i < 3; i++) begin
        cnt_q[i] <= '0;
      end
    end else begin
      if (wr_en && reg_addr_i == REG_CONFIG) begin
        setback_en_q        <= reg_wdata_i[0];
        reload_setback_en_q <= reg_wdata_i[1];
      end
      // State bits of REG_MODE are read only
      if (wr_en && reg_addr_i == REG_MODE) begin
        restore_mode_q <= reg_wdata_i[0];
      end
      if (wr_en && reg_addr_i == REG_SP_STORE) begin
        sp_store_q <= reg_wdata_i;
      end
      // A clear wins over an increment in the same cycle
      for (int i = 0; i < 3; i++) begin
        if (cnt_clr[i]) begin
          cnt_q[i] <= '0;
        end else if (count_inc_i[i] && cnt_q[i] != cnt_max) begin
          cnt_q[i] <= cnt_q[i] + 1'b1;
        end
      end
    end
  end

  always_comb begin
    case (reg_addr_i)
      REG_CONFIG:    reg_rdata_o = data_t'({reload_setback_en_q, setback_en_q});
      REG_MODE:      reg_rdata_o = data_t'({mode_i, restore_mode_q});
      REG_SP_STORE:  reg_rdata_o = sp_store_q;
      REG_MISMATCH0: reg_rdata_o = data_t'(cnt_q[0]);
      REG_MISMATCH1: reg_rdata_o = data_t'(cnt_q[1]);
      REG_MISMATCH2: reg_rdata_o = data_t'(cnt_q[2]);
      default:       reg_rdata_o = '0;
    endcase
  end

  assign setback_en_o        = setback_en_q;
  assign reload_setback_en_o = reload_setback_en_q;
  assign restore_mode_o      = restore_mode_q;
  assign sp_store_o          = sp_store_q;

  // A saturated counter only leaves its maximum through a clear
  for (genvar i = 0; i < 3; i++) begin : gen_sat_chk
    assert property (@(posedge clk_i) disable iff (!rst_ni)
      (cnt_q[i] == cnt_max) && !cnt_clr[i] |=> (cnt_q[i] == cnt_max))
      else $error("mismatch counter %0d wrapped", i);
  end

endmodule

// ==== src/tcls_voter.sv ====
// Purely combinational 2-of-3 voter; blame and multi-error flags settle in the same cycle
`timescale 1ns/1ps

module tcls_voter #(
  parameter int unsigned Width = 1
) (
  input  logic [Width-1:0]         a_i,
  input  logic [Width-1:0]         b_i,
  input  logic [Width-1:0]         c_i,
  output logic [Width-1:0]         majority_o,
  output tcls_bus_pkg::core_mask_t error_cba_o,
  output logic                     multi_error_o
);

  // Bitwise majority of the three inputs
  assign majority_o = (a_i & b_i) | (a_i & c_i) | (b_i & c_i);

  // An input is blamed if any of its bits was outvoted
  assign error_cba_o[0] = (a_i != majority_o);
  assign error_cba_o[1] = (b_i != majority_o);
  assign error_cba_o[2] = (c_i != majority_o);

  // Two or more inputs outvoted, each in different bits
  assign multi_error_o = (error_cba_o[0] & error_cba_o[1]) |
                         (error_cba_o[0] & error_cba_o[2]) |
                         (error_cba_o[1] & error_cba_o[2]);

endmodule

// ==== src/tcls_reg_pkg.sv ====
// Register map and recovery state types; offsets are byte addresses of 32-bit registers
`include "tcls_config.svh"

package tcls_reg_pkg;

  // Register byte offset
  typedef logic [`TCLS_REG_ADDR_W-1:0] reg_addr_t;

  // Mismatch count of one core
  typedef logic [`TCLS_CNT_W-1:0] cnt_t;

  // Recovery state, readable in REG_MODE bits 2:1
  typedef enum logic [1:0] {
    TCLS_RUN    = 2'd0,
    TCLS_UNLOAD = 2'd1,
    TCLS_RELOAD = 2'd2
  } tcls_mode_e;

  // Bit 0 setback enable, bit 1 reload setback enable
  localparam reg_addr_t REG_CONFIG    = 5'h00;
  // Bit 0 restore mode, bits 2:1 current state
  localparam reg_addr_t REG_MODE      = 5'h04;
  localparam reg_addr_t REG_SP_STORE  = 5'h08;
  // Any write clears the counter
  localparam reg_addr_t REG_MISMATCH0 = 5'h0C;
  localparam reg_addr_t REG_MISMATCH1 = 5'h10;
  localparam reg_addr_t REG_MISMATCH2 = 5'h14;

endpackage

// ==== src/tcls_bus_pkg.sv ====
// Bus-side vector types; widths come from tcls_config.svh and the core count is fixed at 3
`include "tcls_config.svh"

package tcls_bus_pkg;

  // One word address on the instruction and data bus
  typedef logic [`TCLS_ADDR_W-1:0] addr_t;

  // Data or instruction word, also used for the interrupt lines
  typedef logic [`TCLS_DATA_W-1:0] data_t;

  // Byte enables of a data access
  typedef logic [`TCLS_BE_W-1:0] be_t;

  // Acknowledged interrupt id
  typedef logic [`TCLS_IRQ_ID_W-1:0] irq_id_t;

  // Bit 0 is core a, bit 2 is core c
  typedef logic [2:0] core_mask_t;

endpackage

// ==== src/tcls_config.svh ====
// Bus and counter widths shared by all TCLS files; the register map assumes 32-bit data
`ifndef TCLS_CONFIG_SVH
`define TCLS_CONFIG_SVH

// Bus side
`define TCLS_ADDR_W 32
`define TCLS_DATA_W 32
`define TCLS_BE_W 4

// Interrupt acknowledge id
`define TCLS_IRQ_ID_W 5

// Per-core mismatch counter, saturating
`define TCLS_CNT_W 8

// Register byte offsets up to 0x1F
`define TCLS_REG_ADDR_W 5

`endif
